// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    // word widths
    localparam int instrWidth = 38;                // opcode + s + a + b
    localparam int dataWidth  = 16;                // registers and data words
    localparam int addrWidth  = 12;                // pc and data addresses
    localparam int memDepth   = 1 << addrWidth;    // both memories are 4096 deep

    // register file
    localparam int regCount = 13;                  // r0..r12, r13..r15 read zero
    localparam int selWidth = 4;                   // register select field

    // instruction layout, msb first: opcode s a b
    localparam int opcodeWidth = 4;
    localparam int modeWidth   = 2;                // s field
    localparam int fieldWidth  = 16;               // a and b fields

    // register fields inside a and b
    localparam int dstLsb     = 12;                // a[15:12] dest, b[15:12] source
    localparam int aluRegLsb  = 8;                 // a[11:8] / b[11:8] for alu ops
    localparam int immLoWidth = 8;                 // alu immediate a[7:0]

    typedef enum logic [opcodeWidth-1:0] {
        OP_NOP = 4'd0,
        OP_MOV = 4'd1,
        OP_LDR = 4'd2,
        OP_STR = 4'd3,
        OP_CMP = 4'd4,
        OP_B   = 4'd5,
        OP_BGT = 4'd6,
        OP_BLT = 4'd7,
        OP_BEQ = 4'd8,
        OP_ADD = 4'd9,
        OP_SUB = 4'd10,
        OP_MUL = 4'd11,
        OP_LSR = 4'd12,
        OP_AND = 4'd13,
        OP_ORR = 4'd14,
        OP_MVN = 4'd15
    } opcodeT;

    // all-zero word decodes as nop
    typedef struct packed {
        opcodeT                opcode; // bits 37:34
        logic [modeWidth-1:0]  s;      // bit1 selects reg for A, bit0 for B
        logic [fieldWidth-1:0] a;      // dest / first operand field
        logic [fieldWidth-1:0] b;      // second operand or address field
    } instrT;

endpackage

// ==== rtl/instrMem.sv ====
`timescale 1ns/1ps

module instrMem import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 progWe,     // load strobe while the core is stopped
    input  logic [addrWidth-1:0] progAddr,
    input  instrT                progData,
    input  logic [addrWidth-1:0] pc,
    output instrT                instruction
);

    // two-state storage so untouched words fetch as nop
    bit [instrWidth-1:0] store [memDepth];

    // load port
    always_ff @(posedge clk) begin
        if (progWe) begin
            store[progAddr] <= progData;   // whole 38-bit word at once
        end
    end

    // asynchronous fetch by pc
    always_comb begin
        instruction = instrT'(store[pc]);  // reinterpret raw bits as fields
    end

endmodule

// ==== rtl/decoder.sv ====
`timescale 1ns/1ps

interface decodeIf import cpuPkg::*; ();
    opcodeT               opcode;
    logic [selWidth-1:0]  rd;          // write-back register, a[15:12]
    logic [selWidth-1:0]  selA;        // register file read port A
    logic [selWidth-1:0]  selB;        // register file read port B
    logic [dataWidth-1:0] opA;         // first operand after imm/reg choice
    logic [dataWidth-1:0] opB;         // second operand after imm/reg choice
    logic [addrWidth-1:0] memAddr;     // b[11:0], data address or branch target
    logic                 useIndirect; // ldr through a pointer word
    logic                 writesReg;   // instruction has a register result

    modport dec (output opcode, rd, selA, selB, opA, opB, memAddr, useIndirect,
                 writesReg);
    modport core (input opcode, rd, selA, selB, opA, opB, memAddr, useIndirect,
                  writesReg);
endinterface

module decoder import cpuPkg::*; (
    input  instrT                instruction,
    input  logic [dataWidth-1:0] regA,  // data for d.selA
    input  logic [dataWidth-1:0] regB,  // data for d.selB
    decodeIf.dec                 d
);

    logic [selWidth-1:0]  dstField;     // a[15:12]
    logic [selWidth-1:0]  srcField;     // b[15:12]
    logic [dataWidth-1:0] immA;         // a[7:0] zero-extended
    logic                 isAlu;

    assign dstField = instruction.a[dstLsb +: selWidth];
    assign srcField = instruction.b[dstLsb +: selWidth];
    assign immA     = {{(dataWidth-immLoWidth){1'b0}}, instruction.a[immLoWidth-1:0]};
    assign isAlu    = instruction.opcode >= OP_ADD;   // add..mvn are contiguous

    // selects depend on the instruction only, kept apart from operand muxing
    always_comb begin
        d.opcode      = instruction.opcode;
        d.rd          = dstField;
        d.memAddr     = instruction.b[addrWidth-1:0];
        d.useIndirect = (instruction.opcode == OP_LDR) && instruction.s[0];
        d.writesReg   = isAlu || (instruction.opcode == OP_MOV)
                        || (instruction.opcode == OP_LDR);
        d.selA        = isAlu ? instruction.a[aluRegLsb +: selWidth] : dstField;
        d.selB        = isAlu ? instruction.b[aluRegLsb +: selWidth] : srcField;
    end

    // operand choice from s
    always_comb begin
        d.opA = regA;                                   // str/cmp: register a[15:12]
        d.opB = instruction.s[0] ? regB : instruction.b; // mov, cmp and alu agree on B
        if (isAlu) begin
            d.opA = instruction.s[1] ? regA : immA;
        end else if (instruction.opcode == OP_STR && instruction.s[0]) begin
            d.opA = instruction.a;                      // store immediate
        end
    end

endmodule

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [selWidth-1:0]  selA,
    input  logic [selWidth-1:0]  selB,
    output logic [dataWidth-1:0] regA,
    output logic [dataWidth-1:0] regB,
    input  logic                 we,
    input  logic [selWidth-1:0]  wrSel,
    input  logic [dataWidth-1:0] wrData
);

    logic [dataWidth-1:0] regs [regCount];   // r0..r12

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wrSel < regCount) begin
            regs[wrSel] <= wrData;           // r13..r15 silently dropped
        end
    end

    // async reads, missing registers give zero
    always_comb begin
        regA = '0;
        regB = '0;
        if (selA < regCount) begin
            regA = regs[selA];
        end
        if (selB < regCount) begin
            regB = regs[selB];
        end
    end

    // a clean reset plus two-state instruction fields keeps operands known
    readKnown: assert property (@(posedge clk) disable iff (!rstN)
        !$isunknown({regA, regB}))
        else $error("%t regFile read data unknown, selA=%0d selB=%0d", $time, selA, selB);

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  opcodeT               opcode,
    input  logic [dataWidth-1:0] opA,
    input  logic [dataWidth-1:0] opB,
    output logic [dataWidth-1:0] result,
    output logic                 gt,     // unsigned opA > opB
    output logic                 lt,     // unsigned opA < opB
    output logic                 eq
);

    logic [2*dataWidth-1:0] product;     // full width, low half kept

    assign product = opA * opB;

    always_comb begin
        result = '0;                     // non-alu opcodes, core ignores it
        case (opcode)
            OP_ADD: begin
                result = opA + opB;      // carry dropped
            end
            OP_SUB: begin
                result = opA - opB;      // wraps on borrow
            end
            OP_MUL: begin
                result = product[dataWidth-1:0];
            end
            OP_LSR: begin
                result = opA >> opB[3:0]; // only 0..15 makes sense for 16 bits
            end
            OP_AND: begin
                result = opA & opB;
            end
            OP_ORR: begin
                result = opA | opB;
            end
            OP_MVN: begin
                result = ~opB;           // opA unused
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // flags always computed, the core latches them on cmp only
    always_comb begin
        gt = opA > opB;
        lt = opA < opB;
        eq = opA == opB;
    end

endmodule

// ==== rtl/dataMem.sv ====
`timescale 1ns/1ps

module dataMem import cpuPkg::*; (
    input  logic                 clk,
    input  logic [addrWidth-1:0] rdAddr,       // direct address b[11:0]
    output logic [dataWidth-1:0] rdData,
    input  logic [addrWidth-1:0] indirectAddr, // pointer taken from rdData
    output logic [dataWidth-1:0] indirectData,
    input  logic                 storeEn,
    input  logic [addrWidth-1:0] storeAddr,
    input  logic [dataWidth-1:0] storeData
);

    // two-state, so reads of never-written words give 0
    bit [dataWidth-1:0] mem [memDepth];

    // both read ports are pure lookups
    always_comb begin
        rdData       = mem[rdAddr];
        indirectData = mem[indirectAddr];
    end

    // single write port
    always_ff @(posedge clk) begin
        if (storeEn) begin
            mem[storeAddr] <= storeData;
        end
    end

    // a store never overlaps a load in one instruction, so no bypass needed

endmodule

// ==== rtl/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 run,           // one instruction per edge while high
    output logic [addrWidth-1:0] pc,
    input  instrT                instruction,
    output logic [addrWidth-1:0] rdAddr,
    input  logic [dataWidth-1:0] rdData,
    output logic [addrWidth-1:0] indirectAddr,
    input  logic [dataWidth-1:0] indirectData,
    output logic                 storeEn,
    output logic [addrWidth-1:0] storeAddr,
    output logic [dataWidth-1:0] storeData,
    output logic                 retireValid,
    output logic [addrWidth-1:0] retirePc,
    output logic                 wbEn,
    output logic [selWidth-1:0]  wbReg,
    output logic [dataWidth-1:0] wbData
);

    decodeIf dIf ();

    logic [dataWidth-1:0] regA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] aluResult;
    logic                 aluGt;
    logic                 aluLt;
    logic                 aluEq;
    logic                 gtFlag;
    logic                 ltFlag;
    logic                 eqFlag;
    logic                 takeBranch;
    logic [addrWidth-1:0] nextPc;

    decoder uDec (.instruction(instruction), .regA(regA), .regB(regB), .d(dIf.dec));

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .selA(dIf.selA), .selB(dIf.selB),
        .regA(regA), .regB(regB),
        .we(wbEn), .wrSel(dIf.rd), .wrData(wbData)
    );

    alu uAlu (
        .opcode(dIf.opcode), .opA(dIf.opA), .opB(dIf.opB),
        .result(aluResult), .gt(aluGt), .lt(aluLt), .eq(aluEq)
    );

    // indirect ldr takes its pointer from the low bits of the first read
    assign rdAddr       = dIf.memAddr;
    assign indirectAddr = rdData[addrWidth-1:0];
    assign storeEn      = run && (dIf.opcode == OP_STR);
    assign storeAddr    = dIf.memAddr;
    assign storeData    = dIf.opA;           // reg a[15:12] or immediate a

    // write-back data from the move, load or alu path
    always_comb begin
        unique case (dIf.opcode)
            OP_MOV:  wbData = dIf.opB;
            OP_LDR:  wbData = dIf.useIndirect ? indirectData : rdData;
            default: wbData = aluResult;
        endcase
    end

    assign wbEn        = run && dIf.writesReg && (dIf.rd < regCount); // r13+ not reported
    assign wbReg       = dIf.rd;
    assign retireValid = run;
    assign retirePc    = pc;

    // branch decision uses flags from an earlier cmp
    assign takeBranch = (dIf.opcode == OP_B)
                        || (dIf.opcode == OP_BGT && gtFlag)
                        || (dIf.opcode == OP_BLT && ltFlag)
                        || (dIf.opcode == OP_BEQ && eqFlag);
    assign nextPc = takeBranch ? dIf.memAddr : pc + 1'b1; // wraps at 4096

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            gtFlag <= 1'b0;
            ltFlag <= 1'b0;
            eqFlag <= 1'b0;
        end else if (run) begin
            pc <= nextPc;
            if (dIf.opcode == OP_CMP) begin  // only cmp touches flags
                gtFlag <= aluGt;
                ltFlag <= aluLt;
                eqFlag <= aluEq;
            end
        end
    end

    // nothing retires, writes back or stores while stopped
    noRetireStopped: assert property (@(posedge clk) disable iff (!rstN)
        !run |-> !(retireValid || wbEn || storeEn))
        else $error("%t retire, write-back or store active with run low", $time);

    // decoder writesReg and the str opcode must stay exclusive
    noWbWithStore: assert property (@(posedge clk) disable iff (!rstN)
        !(storeEn && wbEn))
        else $error("%t store and write-back in one cycle at pc %0d", $time, pc);

endmodule

// ==== rtl/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    input  logic                   progWe,    // program load, run low
    input  logic [addrWidth-1:0]   progAddr,
    input  logic [instrWidth-1:0]  progData,
    output logic                   retireValid,
    output logic [addrWidth-1:0]   retirePc,
    output logic                   wbEn,
    output logic [selWidth-1:0]    wbReg,
    output logic [dataWidth-1:0]   wbData,
    output logic                   storeEn,
    output logic [addrWidth-1:0]   storeAddr,
    output logic [dataWidth-1:0]   storeData
);

    logic [addrWidth-1:0] pc;
    instrT                instruction;
    logic [addrWidth-1:0] rdAddr;
    logic [dataWidth-1:0] rdData;
    logic [addrWidth-1:0] indirectAddr;
    logic [dataWidth-1:0] indirectData;

    instrMem uImem (
        .clk(clk), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .pc(pc), .instruction(instruction)
    );

    cpuCore uCore (
        .clk(clk), .rstN(rstN), .run(run), .pc(pc), .instruction(instruction),
        .rdAddr(rdAddr), .rdData(rdData),
        .indirectAddr(indirectAddr), .indirectData(indirectData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
        .retireValid(retireValid), .retirePc(retirePc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

    dataMem uDmem (
        .clk(clk), .rdAddr(rdAddr), .rdData(rdData),
        .indirectAddr(indirectAddr), .indirectData(indirectData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

endmodule

// ==== verif/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [dataWidth-1:0] mRegs [regCount];   // r0..r12
logic [dataWidth-1:0] mMem [memDepth];    // reset leaves it alone, same as the dut memory
logic [addrWidth-1:0] mPc;
logic                 mGt;
logic                 mLt;
logic                 mEq;

// expected retire outputs of the instruction last stepped
logic [addrWidth-1:0] expPc;
logic                 expWbEn;
logic [selWidth-1:0]  expWbReg;
logic [dataWidth-1:0] expWbData;
logic                 expStEn;
logic [addrWidth-1:0] expStAddr;
logic [dataWidth-1:0] expStData;

function automatic logic [dataWidth-1:0] readModelReg(input logic [3:0] n);
    if (n > 4'd12) begin
        return '0;                        // r13..r15 do not exist
    end
    return mRegs[n];
endfunction

task automatic resetModel();
    for (int i = 0; i < regCount; i++) begin
        mRegs[i] = '0;
    end
    mPc = '0;
    mGt = 1'b0;
    mLt = 1'b0;
    mEq = 1'b0;
endtask

task automatic clearModelMem();
    for (int i = 0; i < memDepth; i++) begin
        mMem[i] = '0;                     // dut memory powers up as zero
    end
endtask

// one instruction: fill in the expected outputs, then update the state
task automatic stepModel(input instrT ins);
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] cmpA;
    logic [dataWidth-1:0] cmpB;
    logic [dataWidth-1:0] res;
    logic [3:0]           rd;
    logic                 writes;
    logic                 jump;
    rd     = ins.a[15:12];
    opA    = ins.s[1] ? readModelReg(ins.a[11:8]) : {8'h00, ins.a[7:0]};
    opB    = ins.s[0] ? readModelReg(ins.b[11:8]) : ins.b;
    cmpA   = readModelReg(rd);
    cmpB   = ins.s[0] ? readModelReg(ins.b[15:12]) : ins.b;
    res    = '0;
    jump   = 1'b0;
    writes = ins.opcode inside {OP_MOV, OP_LDR, OP_ADD, OP_SUB, OP_MUL, OP_LSR,
                                OP_AND, OP_ORR, OP_MVN};
    expPc     = mPc;
    expStEn   = (ins.opcode == OP_STR);
    expStAddr = ins.b[11:0];
    expStData = ins.s[0] ? ins.a : readModelReg(rd);   // immediate or register store
    case (ins.opcode)
        OP_MOV: res = ins.s[0] ? readModelReg(ins.b[15:12]) : ins.b;
        OP_LDR: begin
            res = mMem[ins.b[11:0]];
            if (ins.s[0]) begin
                res = mMem[res[11:0]];    // follow the pointer word
            end
        end
        OP_CMP: begin
            mGt = cmpA > cmpB;            // unsigned
            mLt = cmpA < cmpB;
            mEq = cmpA == cmpB;
        end
        OP_B:   jump = 1'b1;
        OP_BGT: jump = mGt;
        OP_BLT: jump = mLt;
        OP_BEQ: jump = mEq;
        OP_ADD: res = opA + opB;
        OP_SUB: res = opA - opB;
        OP_MUL: res = opA * opB;          // low half only
        OP_LSR: res = opA >> opB[3:0];
        OP_AND: res = opA & opB;
        OP_ORR: res = opA | opB;
        OP_MVN: res = ~opB;
        default: res = '0;
    endcase
    expWbEn   = writes && (rd < 4'd13);   // missing registers take no write
    expWbReg  = rd;
    expWbData = res;
    if (expWbEn) begin
        mRegs[rd] = res;
    end
    if (expStEn) begin
        mMem[expStAddr] = expStData;
    end
    mPc = jump ? ins.b[11:0] : mPc + 12'd1;   // wraps at 4096
endtask

`endif

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    localparam int progDepth   = 64;          // words loaded per test, rest stays nop
    localparam int maxLen      = 48;          // longest random program
    localparam int tailCycles  = 6;           // nops run after the program
    localparam int resetCycles = 3;
    localparam int pauseLen    = 5;
    localparam int numTests    = 5;
    localparam int testCycles  = progDepth + 1 + resetCycles + 2 + maxLen + tailCycles;
    localparam int cycleLimit  = numTests * testCycles + pauseLen + resetCycles + 100;
    localparam logic [addrWidth-1:0] winBase = 12'h100;   // data window for ldr/str

    localparam int movTest    = 0;
    localparam int aluTest    = 1;
    localparam int memTest    = 2;
    localparam int branchTest = 3;
    localparam int pauseTest  = 4;

    logic                  clk;
    logic                  rstN;
    logic                  run;
    logic                  progWe;
    logic [addrWidth-1:0]  progAddr;
    logic [instrWidth-1:0] progData;
    logic                  retireValid;
    logic [addrWidth-1:0]  retirePc;
    logic                  wbEn;
    logic [selWidth-1:0]   wbReg;
    logic [dataWidth-1:0]  wbData;
    logic                  storeEn;
    logic [addrWidth-1:0]  storeAddr;
    logic [dataWidth-1:0]  storeData;

    instrT       prog [progDepth];            // image of the instruction store
    logic [31:0] lfsrState;
    int          errorCount;
    int          checkCount;
    int          testCount;
    int          cycleCount;

    `include "isaModel.svh"

    cpuTop uut (
        .clk(clk), .rstN(rstN), .run(run),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .retireValid(retireValid), .retirePc(retirePc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                // 10 ns period
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);   // one step per bit
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] randReg();
        return 4'(randBits(8) % 13);
    endfunction

    function automatic instrT makeInstr(input opcodeT op, input logic [1:0] s,
                                        input logic [15:0] a, input logic [15:0] b);
        return {op, s, a, b};
    endfunction

    // rd and b[15:12] span 0..15 so r13..r15 get exercised
    function automatic instrT movInstr(input logic immOnly);
        logic [1:0] s;
        s = immOnly ? 2'b00 : {1'b0, randBits(1) == 32'd1};
        return makeInstr(OP_MOV, s, {immOnly ? randReg() : 4'(randBits(4)), 12'h000},
                         16'(randBits(16)));
    endfunction

    function automatic instrT aluInstr();
        opcodeT     op;
        logic [1:0] s;
        logic [3:0] rd;
        logic [3:0] ra;
        op = opcodeT'(4'(9 + randBits(8) % 7));   // add..mvn
        s  = 2'(randBits(2));                     // all four operand modes
        rd = randReg();
        ra = randReg();
        return makeInstr(op, s, {rd, ra, 8'(randBits(8))},
                         s[0] ? {4'h0, randReg(), 8'(randBits(8))} : 16'(randBits(16)));
    endfunction

    function automatic instrT memInstr();
        logic [addrWidth-1:0] wAddr;
        logic [15:0]          imm;
        int                   c;
        c     = int'(randBits(8) % 4);
        wAddr = winBase + 12'(randBits(3));
        case (c)
            0: return makeInstr(OP_STR, 2'b00, {randReg(), 12'h000}, {4'h0, wAddr});
            1: begin
                imm = randBits(1) == 32'd1 ? {4'h0, winBase + 12'(randBits(3))}
                                           : 16'(randBits(16));   // often a pointer
                return makeInstr(OP_STR, 2'b01, imm, {4'h0, wAddr});
            end
            2: return makeInstr(OP_LDR, 2'b00, {randReg(), 12'h000}, {4'h0, wAddr});
            default: return makeInstr(OP_LDR, 2'b01, {randReg(), 12'h000}, {4'h0, wAddr});
        endcase
    endfunction

    // small values make eq likely, targets stay forward and inside the program
    function automatic instrT branchSlotInstr(input int i, input int n);
        int         c;
        int         tgt;
        logic [1:0] s;
        c = int'(randBits(8) % 4);
        if (c == 0) begin
            return makeInstr(OP_MOV, 2'b00, {randReg(), 12'h000}, 16'(randBits(2)));
        end
        if (c == 1) begin
            s = {1'b0, randBits(1) == 32'd1};
            return makeInstr(OP_CMP, s, {randReg(), 12'h000},
                             s[0] ? {randReg(), 12'h000} : 16'(randBits(2)));
        end
        tgt = i + 1 + int'(randBits(2));
        if (tgt > n) begin
            tgt = n;
        end
        return makeInstr(opcodeT'(4'(5 + randBits(2))), 2'b00, 16'h0000,
                         {4'h0, 12'(tgt)});
    endfunction

    task automatic buildProgram(input int kind, input int n);
        int i;
        for (i = 0; i < progDepth; i++) begin
            prog[i] = '0;                     // nop
        end
        for (i = 0; i < n; i++) begin
            case (kind)
                movTest:    prog[i] = movInstr(1'b0);
                memTest:    prog[i] = (i < 4) ? movInstr(1'b1) : memInstr();
                branchTest: prog[i] = branchSlotInstr(i, n);
                default:    prog[i] = (i < 6) ? movInstr(1'b1) : aluInstr();
            endcase
        end
    endtask

    task automatic loadProgram();
        int i;
        for (i = 0; i < progDepth; i++) begin
            @(negedge clk);
            progWe   = 1'b1;
            progAddr = 12'(i);
            progData = prog[i];
        end
        @(negedge clk);
        progWe = 1'b0;
    endtask

    task automatic pulseReset();
        @(negedge clk);
        run  = 1'b0;
        rstN = 1'b0;
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;
        resetModel();
    endtask

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("error %0t: %s is %0h, expected %0h (pc %0h)", $time, what, got, exp,
                     expPc);
            errorCount++;
        end
    endtask

    function automatic instrT fetchAtPc();
        return (mPc < progDepth) ? prog[mPc] : instrT'('0);
    endfunction

    task automatic checkRetire();
        stepModel(fetchAtPc());
        checkValue("retireValid", 32'(retireValid), 32'd1);
        checkValue("retirePc", 32'(retirePc), 32'(expPc));
        checkValue("wbEn", 32'(wbEn), 32'(expWbEn));
        if (expWbEn) begin
            checkValue("wbReg", 32'(wbReg), 32'(expWbReg));
            checkValue("wbData", 32'(wbData), 32'(expWbData));
        end
        checkValue("storeEn", 32'(storeEn), 32'(expStEn));
        if (expStEn) begin
            checkValue("storeAddr", 32'(storeAddr), 32'(expStAddr));
            checkValue("storeData", 32'(storeData), 32'(expStData));
        end
    endtask

    // outputs are sampled 2 ns after the falling edge, well before the rising one
    task automatic runProgram(input int cycles, input int pauseAt);
        int cyc;
        int stopped;
        cyc     = 0;
        stopped = 0;
        while (cyc < cycles) begin
            @(negedge clk);
            if (cyc == pauseAt && stopped < pauseLen) begin
                run = 1'b0;                   // model is not stepped while stopped
                stopped++;
                #2;
                checkValue("retireValid while stopped", 32'(retireValid), 32'd0);
                checkValue("wbEn while stopped", 32'(wbEn), 32'd0);
                checkValue("storeEn while stopped", 32'(storeEn), 32'd0);
            end else begin
                run = 1'b1;
                #2;
                checkRetire();
                cyc++;
            end
        end
        @(negedge clk);
        run = 1'b0;
    endtask

    task automatic runTest(input string name, input int kind, input int n, input int pauseAt);
        int errsBefore;
        int checksBefore;
        errsBefore   = errorCount;
        checksBefore = checkCount;
        buildProgram(kind, n);
        loadProgram();
        pulseReset();
        runProgram(n + tailCycles, pauseAt);
        testCount++;
        $display("test %-7s %0d checks, %0d errors", name, checkCount - checksBefore,
                 errorCount - errsBefore);
    endtask

    initial begin
        rstN       = 1'b0;
        run        = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        lfsrState  = 32'hdd23_d4df;
        errorCount = 0;
        checkCount = 0;
        testCount  = 0;
        cycleCount = 0;
        clearModelMem();
        resetModel();
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        runTest("mov", movTest, 40, -1);
        runTest("alu", aluTest, maxLen, -1);
        runTest("mem", memTest, maxLen, -1);
        runTest("branch", branchTest, maxLen, -1);
        runTest("pause", pauseTest, 40, 17);  // run drops at the 18th instruction

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+verif
rtl/cpuPkg.sv
rtl/instrMem.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/dataMem.sv
rtl/cpuCore.sv
rtl/cpuTop.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpuTb simulation with Verilator, then check sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f tb.f \
    -o cpuTbSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
{ ./obj_dir/cpuTbSim > sim.log 2>&1 || true; } && cat sim.log
grep -qx "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
